//--- sources.f
rob_pkg.sv
rob_if.sv
rob_dispatch_decode.sv
rob_ptr_ctrl.sv
rob_entry_store.sv
rob_commit.sv
rob_top.sv
rob_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rob_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- rob_tb.sv
`timescale 1ns/100ps

module rob_tb;
    import rob_pkg::*;

    localparam int CLK_NS        = 4;
    localparam int N_INSTR       = 400;
    // worst case retire latency per instruction, in cycles
    localparam int CYC_PER_INSTR = 24;
    localparam int WATCHDOG_NS   = (N_INSTR * CYC_PER_INSTR + 20) * CLK_NS;

    logic                  clk;
    logic                  rst;
    logic                  dispatch_valid;
    logic [XLEN-1:0]       dispatch_inst;
    logic [XLEN-1:0]       dispatch_pc_rdata;
    logic [XLEN-1:0]       dispatch_pc_wdata;
    logic [ARCH_REG_W-1:0] dispatch_rd_addr;
    logic [ARCH_REG_W-1:0] dispatch_rs1_addr;
    logic [ARCH_REG_W-1:0] dispatch_rs2_addr;
    logic [PHYS_REG_W-1:0] dispatch_pd;
    logic                  dispatch_regf_we;
    logic                  dispatch_ready;
    logic [ROB_IDX_W-1:0]  dispatch_idx;
    logic                  alu_valid;
    logic [ROB_IDX_W-1:0]  alu_idx;
    logic [XLEN-1:0]       alu_rd_wdata;
    logic                  mem_valid;
    logic [ROB_IDX_W-1:0]  mem_idx;
    logic [XLEN-1:0]       mem_rd_wdata;
    logic                  br_valid;
    logic [ROB_IDX_W-1:0]  br_idx;
    logic [XLEN-1:0]       br_rd_wdata;
    logic                  br_taken;
    logic [XLEN-1:0]       br_target;
    logic                  commit_valid;
    logic [ORDER_W-1:0]    commit_order;
    logic [XLEN-1:0]       commit_inst;
    logic [XLEN-1:0]       commit_pc_rdata;
    logic [XLEN-1:0]       commit_pc_wdata;
    logic [ARCH_REG_W-1:0] commit_rd_addr;
    logic [ARCH_REG_W-1:0] commit_rs1_addr;
    logic [ARCH_REG_W-1:0] commit_rs2_addr;
    logic [PHYS_REG_W-1:0] commit_pd;
    logic                  commit_regf_we;
    logic [XLEN-1:0]       commit_rd_wdata;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_addr;

    // reference model, one record per buffer slot
    logic [XLEN-1:0]       exp_inst     [ROB_DEPTH];
    logic [XLEN-1:0]       exp_pc_rdata [ROB_DEPTH];
    logic [XLEN-1:0]       exp_pc_wdata [ROB_DEPTH];
    logic [ARCH_REG_W-1:0] exp_rd       [ROB_DEPTH];
    logic [ARCH_REG_W-1:0] exp_rs1      [ROB_DEPTH];
    logic [ARCH_REG_W-1:0] exp_rs2      [ROB_DEPTH];
    logic [PHYS_REG_W-1:0] exp_pd       [ROB_DEPTH];
    logic                  exp_we       [ROB_DEPTH];
    logic [XLEN-1:0]       exp_wdata    [ROB_DEPTH];
    logic                  exp_done     [ROB_DEPTH];
    logic                  exp_taken    [ROB_DEPTH];
    logic [XLEN-1:0]       exp_target   [ROB_DEPTH];
    // slots in program order, oldest first
    logic [ROB_IDX_W-1:0]  q [$];
    logic [ROB_IDX_W-1:0]  exp_tail;
    logic [ORDER_W-1:0]    exp_order;
    int                    n_disp;
    logic [31:0]           seed = 32'h7cca6496;

    rob_top u_rob_top (.*);

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic rv_opcode_e opcode_at(input int k);
        case (k)
            0: return op_lui;
            1: return op_auipc;
            2: return op_jal;
            3: return op_jalr;
            4: return op_br;
            5: return op_load;
            6: return op_store;
            7: return op_imm;
            default: return op_reg;
        endcase
    endfunction

    // register fields that each format really encodes
    function automatic logic has_rd(input rv_opcode_e op);
        return !(op == op_store || op == op_br);
    endfunction

    function automatic logic has_rs1(input rv_opcode_e op);
        return !(op == op_lui || op == op_auipc || op == op_jal);
    endfunction

    function automatic logic has_rs2(input rv_opcode_e op);
        return op == op_reg || op == op_br || op == op_store;
    endfunction

    // 0 alu, 1 mem, 2 branch unit
    function automatic int port_of(input logic [6:0] op);
        if (op == op_br) begin
            return 2;
        end
        if (op == op_load || op == op_store) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_commit(input logic [ROB_IDX_W-1:0] h);
        logic [XLEN-1:0] next_pc;
        next_pc = exp_taken[h] ? exp_target[h] : exp_pc_wdata[h];
        check("commit_order", commit_order, exp_order);
        check("commit_inst", 64'(commit_inst), 64'(exp_inst[h]));
        check("commit_pc_rdata", 64'(commit_pc_rdata), 64'(exp_pc_rdata[h]));
        check("commit_pc_wdata", 64'(commit_pc_wdata), 64'(next_pc));
        check("commit_rd_addr", 64'(commit_rd_addr), 64'(exp_rd[h]));
        check("commit_rs1_addr", 64'(commit_rs1_addr), 64'(exp_rs1[h]));
        check("commit_rs2_addr", 64'(commit_rs2_addr), 64'(exp_rs2[h]));
        check("commit_pd", 64'(commit_pd), 64'(exp_pd[h]));
        check("commit_regf_we", 64'(commit_regf_we), 64'(exp_we[h]));
        check("commit_rd_wdata", 64'(commit_rd_wdata), 64'(exp_wdata[h]));
        if (exp_taken[h]) begin
            check("redirect_addr", 64'(redirect_addr), 64'(exp_target[h]));
        end
    endtask

    task automatic new_request();
        logic [31:0] r;
        r                 = next_rand();
        dispatch_inst     = {r[31:7], opcode_at(int'(r[3:0]) % 9)};
        dispatch_pc_rdata = next_rand();
        dispatch_pc_wdata = dispatch_pc_rdata + 32'd4;
        r                 = next_rand();
        dispatch_rd_addr  = r[4:0];
        dispatch_rs1_addr = r[9:5];
        dispatch_rs2_addr = r[14:10];
        dispatch_pd       = r[20:15];
        dispatch_regf_we  = r[21];
        dispatch_valid    = 1'b1;
    endtask

    task automatic accept_request();
        rv_opcode_e op;
        op = rv_opcode_e'(dispatch_inst[6:0]);
        exp_inst[exp_tail]     = dispatch_inst;
        exp_pc_rdata[exp_tail] = dispatch_pc_rdata;
        exp_pc_wdata[exp_tail] = dispatch_pc_wdata;
        exp_rd[exp_tail]       = has_rd(op) ? dispatch_rd_addr : '0;
        exp_rs1[exp_tail]      = has_rs1(op) ? dispatch_rs1_addr : '0;
        exp_rs2[exp_tail]      = has_rs2(op) ? dispatch_rs2_addr : '0;
        exp_pd[exp_tail]       = dispatch_pd;
        exp_we[exp_tail]       = dispatch_regf_we;
        exp_done[exp_tail]     = 1'b0;
        exp_taken[exp_tail]    = 1'b0;
        q.push_back(exp_tail);
        exp_tail = exp_tail + 1'b1;
        n_disp++;
    endtask

    // random waiting entry of the given unit class, or none
    task automatic pick_completion(input int port, output logic hit,
                                   output logic [ROB_IDX_W-1:0] slot);
        logic [ROB_IDX_W-1:0] cand [$];
        logic [31:0]          r;
        hit  = 1'b0;
        slot = '0;
        foreach (q[i]) begin
            if (!exp_done[q[i]] && port_of(exp_inst[q[i]][6:0]) == port) begin
                cand.push_back(q[i]);
            end
        end
        r = next_rand();
        if (cand.size() > 0 && r[0]) begin
            hit  = 1'b1;
            slot = cand[(r >> 1) % cand.size()];
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the buffer did not retire all instructions in time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic                 exp_commit;
        logic                 exp_redir;
        logic                 exp_ready;
        logic                 took;
        logic                 hit;
        logic [ROB_IDX_W-1:0] h;
        logic [ROB_IDX_W-1:0] slot;
        logic [31:0]          r;
        clk               = 1'b0;
        rst               = 1'b1;
        dispatch_valid    = 1'b0;
        dispatch_inst     = '0;
        dispatch_pc_rdata = '0;
        dispatch_pc_wdata = '0;
        dispatch_rd_addr  = '0;
        dispatch_rs1_addr = '0;
        dispatch_rs2_addr = '0;
        dispatch_pd       = '0;
        dispatch_regf_we  = 1'b0;
        alu_valid         = 1'b0;
        alu_idx           = '0;
        alu_rd_wdata      = '0;
        mem_valid         = 1'b0;
        mem_idx           = '0;
        mem_rd_wdata      = '0;
        br_valid          = 1'b0;
        br_idx            = '0;
        br_rd_wdata       = '0;
        br_taken          = 1'b0;
        br_target         = '0;
        exp_tail          = '0;
        exp_order         = '0;
        n_disp            = 0;
        took              = 1'b0;
        h                 = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (n_disp < N_INSTR || q.size() > 0) begin
            // outputs have settled half a cycle after the edge
            exp_commit = 1'b0;
            exp_redir  = 1'b0;
            if (q.size() > 0) begin
                h          = q[0];
                exp_commit = exp_done[h];
                exp_redir  = exp_commit && exp_taken[h];
            end
            exp_ready = q.size() < ROB_DEPTH && !exp_redir;
            check("dispatch_ready", 64'(dispatch_ready), 64'(exp_ready));
            if (exp_ready) begin
                check("dispatch_idx", 64'(dispatch_idx), 64'(exp_tail));
            end
            check("commit_valid", 64'(commit_valid), 64'(exp_commit));
            check("redirect_valid", 64'(redirect_valid), 64'(exp_redir));
            if (exp_commit) begin
                check_commit(h);
            end

            if (took) begin
                dispatch_valid = 1'b0;
            end
            took      = 1'b0;
            alu_valid = 1'b0;
            mem_valid = 1'b0;
            br_valid  = 1'b0;

            // first fill the buffer with nothing completing
            if (n_disp >= ROB_DEPTH && !exp_redir) begin
                pick_completion(0, hit, slot);
                if (hit) begin
                    alu_valid       = 1'b1;
                    alu_idx         = slot;
                    alu_rd_wdata    = next_rand();
                    exp_done[slot]  = 1'b1;
                    exp_wdata[slot] = alu_rd_wdata;
                end
                pick_completion(1, hit, slot);
                if (hit) begin
                    mem_valid       = 1'b1;
                    mem_idx         = slot;
                    mem_rd_wdata    = next_rand();
                    exp_done[slot]  = 1'b1;
                    exp_wdata[slot] = mem_rd_wdata;
                end
                pick_completion(2, hit, slot);
                if (hit) begin
                    r                = next_rand();
                    br_valid         = 1'b1;
                    br_idx           = slot;
                    br_rd_wdata      = next_rand();
                    br_taken         = r[0];
                    br_target        = {r[31:2], 2'b00};
                    exp_done[slot]   = 1'b1;
                    exp_wdata[slot]  = br_rd_wdata;
                    exp_taken[slot]  = br_taken;
                    exp_target[slot] = br_target;
                end
            end

            if (exp_commit) begin
                void'(q.pop_front());
                exp_order = exp_order + 1'b1;
                // squash everything younger than the branch
                if (exp_redir) begin
                    q.delete();
                    exp_tail = h + 1'b1;
                end
            end

            if (!dispatch_valid && n_disp < N_INSTR) begin
                r = next_rand();
                if (n_disp < ROB_DEPTH || r[1:0] != 2'b00) begin
                    new_request();
                end
            end
            if (dispatch_valid && exp_ready) begin
                accept_request();
                took = 1'b1;
            end
            @(negedge clk);
        end

        // drained buffer
        check("commit_valid", 64'(commit_valid), 64'(1'b0));
        check("dispatch_ready", 64'(dispatch_ready), 64'(1'b1));
        check("commit_order", commit_order, exp_order);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- rob_top.sv
`timescale 1ns/100ps

module rob_top (
    input  logic                           clk,
    input  logic                           rst,

    // dispatch
    input  logic                           dispatch_valid,
    input  logic [rob_pkg::XLEN-1:0]       dispatch_inst,
    input  logic [rob_pkg::XLEN-1:0]       dispatch_pc_rdata,
    input  logic [rob_pkg::XLEN-1:0]       dispatch_pc_wdata,
    input  logic [rob_pkg::ARCH_REG_W-1:0] dispatch_rd_addr,
    input  logic [rob_pkg::ARCH_REG_W-1:0] dispatch_rs1_addr,
    input  logic [rob_pkg::ARCH_REG_W-1:0] dispatch_rs2_addr,
    input  logic [rob_pkg::PHYS_REG_W-1:0] dispatch_pd,
    input  logic                           dispatch_regf_we,
    output logic                           dispatch_ready,
    output logic [rob_pkg::ROB_IDX_W-1:0]  dispatch_idx,

    // completions
    input  logic                           alu_valid,
    input  logic [rob_pkg::ROB_IDX_W-1:0]  alu_idx,
    input  logic [rob_pkg::XLEN-1:0]       alu_rd_wdata,
    input  logic                           mem_valid,
    input  logic [rob_pkg::ROB_IDX_W-1:0]  mem_idx,
    input  logic [rob_pkg::XLEN-1:0]       mem_rd_wdata,
    input  logic                           br_valid,
    input  logic [rob_pkg::ROB_IDX_W-1:0]  br_idx,
    input  logic [rob_pkg::XLEN-1:0]       br_rd_wdata,
    input  logic                           br_taken,
    input  logic [rob_pkg::XLEN-1:0]       br_target,

    // commit
    output logic                           commit_valid,
    output logic [rob_pkg::ORDER_W-1:0]    commit_order,
    output logic [rob_pkg::XLEN-1:0]       commit_inst,
    output logic [rob_pkg::XLEN-1:0]       commit_pc_rdata,
    output logic [rob_pkg::XLEN-1:0]       commit_pc_wdata,
    output logic [rob_pkg::ARCH_REG_W-1:0] commit_rd_addr,
    output logic [rob_pkg::ARCH_REG_W-1:0] commit_rs1_addr,
    output logic [rob_pkg::ARCH_REG_W-1:0] commit_rs2_addr,
    output logic [rob_pkg::PHYS_REG_W-1:0] commit_pd,
    output logic                           commit_regf_we,
    output logic [rob_pkg::XLEN-1:0]       commit_rd_wdata,
    output logic                           redirect_valid,
    output logic [rob_pkg::XLEN-1:0]       redirect_addr
);
    import rob_pkg::*;

    rob_entry_t new_entry;
    rob_entry_t head_entry;

    rob_cdb_if  alu_cdb ();
    rob_cdb_if  mem_cdb ();
    rob_cdb_if  br_cdb ();
    rob_ctrl_if ctrl_bus ();

    // alu and mem never redirect
    assign alu_cdb.valid     = alu_valid;
    assign alu_cdb.idx       = alu_idx;
    assign alu_cdb.rd_wdata  = alu_rd_wdata;
    assign alu_cdb.br_taken  = 1'b0;
    assign alu_cdb.br_target = '0;

    assign mem_cdb.valid     = mem_valid;
    assign mem_cdb.idx       = mem_idx;
    assign mem_cdb.rd_wdata  = mem_rd_wdata;
    assign mem_cdb.br_taken  = 1'b0;
    assign mem_cdb.br_target = '0;

    assign br_cdb.valid      = br_valid;
    assign br_cdb.idx        = br_idx;
    assign br_cdb.rd_wdata   = br_rd_wdata;
    assign br_cdb.br_taken   = br_taken;
    assign br_cdb.br_target  = br_target;

    // index handed to the next accepted dispatch
    assign dispatch_idx = ctrl_bus.alloc_idx;

    rob_dispatch_decode u_decode (
        .inst     (dispatch_inst),
        .pc_rdata (dispatch_pc_rdata),
        .pc_wdata (dispatch_pc_wdata),
        .rd_addr  (dispatch_rd_addr),
        .rs1_addr (dispatch_rs1_addr),
        .rs2_addr (dispatch_rs2_addr),
        .pd       (dispatch_pd),
        .regf_we  (dispatch_regf_we),
        .entry    (new_entry)
    );

    rob_ptr_ctrl u_ptr_ctrl (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .ctrl           (ctrl_bus.ptr)
    );

    rob_entry_store u_entry_store (
        .clk        (clk),
        .rst        (rst),
        .new_entry  (new_entry),
        .alu        (alu_cdb.rob),
        .mem        (mem_cdb.rob),
        .br         (br_cdb.rob),
        .ctrl       (ctrl_bus.store),
        .head_entry (head_entry)
    );

    rob_commit u_commit (
        .clk             (clk),
        .rst             (rst),
        .head_entry      (head_entry),
        .ctrl            (ctrl_bus.commit),
        .commit_valid    (commit_valid),
        .commit_order    (commit_order),
        .commit_inst     (commit_inst),
        .commit_pc_rdata (commit_pc_rdata),
        .commit_pc_wdata (commit_pc_wdata),
        .commit_rd_addr  (commit_rd_addr),
        .commit_rs1_addr (commit_rs1_addr),
        .commit_rs2_addr (commit_rs2_addr),
        .commit_pd       (commit_pd),
        .commit_regf_we  (commit_regf_we),
        .commit_rd_wdata (commit_rd_wdata),
        .redirect_valid  (redirect_valid),
        .redirect_addr   (redirect_addr)
    );

endmodule

//--- rob_commit.sv
`timescale 1ns/100ps

module rob_commit (
    input  logic                           clk,
    input  logic                           rst,
    input  rob_pkg::rob_entry_t            head_entry,
    rob_ctrl_if.commit                     ctrl,
    output logic                           commit_valid,
    output logic [rob_pkg::ORDER_W-1:0]    commit_order,
    output logic [rob_pkg::XLEN-1:0]       commit_inst,
    output logic [rob_pkg::XLEN-1:0]       commit_pc_rdata,
    output logic [rob_pkg::XLEN-1:0]       commit_pc_wdata,
    output logic [rob_pkg::ARCH_REG_W-1:0] commit_rd_addr,
    output logic [rob_pkg::ARCH_REG_W-1:0] commit_rs1_addr,
    output logic [rob_pkg::ARCH_REG_W-1:0] commit_rs2_addr,
    output logic [rob_pkg::PHYS_REG_W-1:0] commit_pd,
    output logic                           commit_regf_we,
    output logic [rob_pkg::XLEN-1:0]       commit_rd_wdata,
    output logic                           redirect_valid,
    output logic [rob_pkg::XLEN-1:0]       redirect_addr
);
    import rob_pkg::*;

    // retirement order of the next commit
    logic [ORDER_W-1:0] order_q;

    // oldest instruction leaves as soon as it is done
    assign ctrl.retire = head_entry.valid && head_entry.done;
    assign ctrl.flush  = ctrl.retire && head_entry.redirect;

    assign commit_valid    = ctrl.retire;
    assign commit_order    = order_q;
    assign commit_inst     = head_entry.inst;
    assign commit_pc_rdata = head_entry.pc_rdata;
    assign commit_pc_wdata = head_entry.pc_wdata;
    assign commit_rd_addr  = head_entry.rd_addr;
    assign commit_rs1_addr = head_entry.rs1_addr;
    assign commit_rs2_addr = head_entry.rs2_addr;
    assign commit_pd       = head_entry.pd;
    assign commit_regf_we  = head_entry.regf_we;
    assign commit_rd_wdata = head_entry.rd_wdata;

    assign redirect_valid = ctrl.flush;
    assign redirect_addr  = head_entry.redirect_addr;

    // keeps counting through flushes
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (ctrl.retire) begin
            order_q <= order_q + 1'b1;
        end
    end

endmodule

//--- rob_entry_store.sv
`timescale 1ns/100ps

module rob_entry_store (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::rob_entry_t new_entry,
    rob_cdb_if.rob              alu,
    rob_cdb_if.rob              mem,
    rob_cdb_if.rob              br,
    rob_ctrl_if.store           ctrl,
    output rob_pkg::rob_entry_t head_entry
);
    import rob_pkg::*;

    rob_entry_t entries [ROB_DEPTH];

    // mark an entry finished with its result and branch outcome
    function automatic rob_entry_t complete(
        input rob_entry_t      e,
        input logic [XLEN-1:0] wdata,
        input logic            taken,
        input logic [XLEN-1:0] target
    );
        rob_entry_t r;
        r               = e;
        r.done          = 1'b1;
        r.rd_wdata      = wdata;
        r.redirect      = taken;
        r.redirect_addr = target;
        // next pc seen at retire is the real one
        if (taken) begin
            r.pc_wdata = target;
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (ctrl.alloc) begin
                entries[ctrl.alloc_idx] <= new_entry;
            end

            // alu and mem ports tie br_taken low
            if (alu.valid) begin
                entries[alu.idx] <= complete(entries[alu.idx], alu.rd_wdata,
                                             alu.br_taken, alu.br_target);
            end
            if (mem.valid) begin
                entries[mem.idx] <= complete(entries[mem.idx], mem.rd_wdata,
                                             mem.br_taken, mem.br_target);
            end
            if (br.valid) begin
                entries[br.idx] <= complete(entries[br.idx], br.rd_wdata,
                                            br.br_taken, br.br_target);
            end

            // valid clears last so it wins over a completion write
            if (ctrl.flush) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    entries[i].valid <= 1'b0;
                end
            end else if (ctrl.retire) begin
                entries[ctrl.head_idx].valid <= 1'b0;
            end
        end
    end

    assign head_entry = entries[ctrl.head_idx];

    // units only complete live entries that are still waiting
    a_alu_live: assert property (@(posedge clk) disable iff (rst)
        alu.valid |-> entries[alu.idx].valid && !entries[alu.idx].done);
    a_mem_live: assert property (@(posedge clk) disable iff (rst)
        mem.valid |-> entries[mem.idx].valid && !entries[mem.idx].done);
    a_br_live: assert property (@(posedge clk) disable iff (rst)
        br.valid |-> entries[br.idx].valid && !entries[br.idx].done);

    // at most one port per index in a cycle
    a_no_collision: assert property (@(posedge clk) disable iff (rst)
        !((alu.valid && mem.valid && alu.idx == mem.idx)
       || (alu.valid && br.valid  && alu.idx == br.idx)
       || (mem.valid && br.valid  && mem.idx == br.idx)));

endmodule

//--- rob_ptr_ctrl.sv
`timescale 1ns/100ps

module rob_ptr_ctrl (
    input  logic    clk,
    input  logic    rst,
    input  logic    dispatch_valid,
    output logic    dispatch_ready,
    rob_ctrl_if.ptr ctrl
);
    import rob_pkg::*;

    logic [ROB_PTR_W-1:0] head;
    logic [ROB_PTR_W-1:0] tail;
    logic [ROB_PTR_W-1:0] head_next;
    logic [ROB_PTR_W-1:0] occupancy;
    logic                 full;

    // same slot, opposite lap
    assign full = (head[ROB_IDX_W-1:0] == tail[ROB_IDX_W-1:0])
               && (head[ROB_IDX_W] != tail[ROB_IDX_W]);

    // no dispatch while the buffer is being squashed
    assign dispatch_ready = !full && !ctrl.flush;
    assign ctrl.alloc     = dispatch_valid && dispatch_ready;

    assign ctrl.alloc_idx = tail[ROB_IDX_W-1:0];
    assign ctrl.head_idx  = head[ROB_IDX_W-1:0];

    assign head_next = head + ROB_PTR_W'(ctrl.retire);
    assign occupancy = tail - head;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= head_next;
            // a redirect leaves the buffer empty just past the branch
            if (ctrl.flush) begin
                tail <= head_next;
            end else if (ctrl.alloc) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // the buffer is never overfilled by an alloc into a full buffer
    a_no_overfill: assert property (@(posedge clk) disable iff (rst)
        occupancy <= ROB_PTR_W'(ROB_DEPTH));

    // commit only retires from a non-empty buffer
    a_retire_nonempty: assert property (@(posedge clk) disable iff (rst)
        ctrl.retire |-> occupancy != '0);

endmodule

//--- rob_dispatch_decode.sv
`timescale 1ns/100ps

module rob_dispatch_decode (
    input  logic [rob_pkg::XLEN-1:0]       inst,
    input  logic [rob_pkg::XLEN-1:0]       pc_rdata,
    input  logic [rob_pkg::XLEN-1:0]       pc_wdata,
    input  logic [rob_pkg::ARCH_REG_W-1:0] rd_addr,
    input  logic [rob_pkg::ARCH_REG_W-1:0] rs1_addr,
    input  logic [rob_pkg::ARCH_REG_W-1:0] rs2_addr,
    input  logic [rob_pkg::PHYS_REG_W-1:0] pd,
    input  logic                           regf_we,
    output rob_pkg::rob_entry_t            entry
);
    import rob_pkg::*;

    rv_opcode_e opcode;
    logic       no_rd;
    logic       no_rs1;
    logic       no_rs2;

    assign opcode = rv_opcode_e'(inst[6:0]);

    // which register fields the opcode actually has
    always_comb begin
        no_rd  = 1'b0;
        no_rs1 = 1'b0;
        no_rs2 = 1'b0;
        case (opcode)
            op_store, op_br: no_rd = 1'b1;
            op_lui, op_auipc, op_jal: begin
                no_rs1 = 1'b1;
                no_rs2 = 1'b1;
            end
            op_imm, op_load, op_jalr: no_rs2 = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        entry               = '0;
        entry.valid         = 1'b1;
        entry.done          = 1'b0;
        entry.inst          = inst;
        entry.pc_rdata      = pc_rdata;
        entry.pc_wdata      = pc_wdata;
        entry.rd_addr       = no_rd  ? '0 : rd_addr;
        entry.rs1_addr      = no_rs1 ? '0 : rs1_addr;
        entry.rs2_addr      = no_rs2 ? '0 : rs2_addr;
        entry.pd            = pd;
        entry.regf_we       = regf_we;
        // result and branch outcome arrive on completion
        entry.rd_wdata      = '0;
        entry.redirect      = 1'b0;
        entry.redirect_addr = '0;
    end

endmodule

//--- rob_if.sv
`timescale 1ns/100ps

// one completion port from an execution unit
interface rob_cdb_if;
    import rob_pkg::*;

    logic                 valid;
    logic [ROB_IDX_W-1:0] idx;
    logic [XLEN-1:0]      rd_wdata;
    // only the branch unit ever sets these
    logic                 br_taken;
    logic [XLEN-1:0]      br_target;

    modport unit (
        output valid, idx, rd_wdata, br_taken, br_target
    );

    modport rob (
        input valid, idx, rd_wdata, br_taken, br_target
    );
endinterface

// pointer control shared by ptr_ctrl, commit and entry_store
interface rob_ctrl_if;
    import rob_pkg::*;

    logic                 alloc;
    logic [ROB_IDX_W-1:0] alloc_idx;
    logic [ROB_IDX_W-1:0] head_idx;
    logic                 retire;
    logic                 flush;

    modport ptr (
        output alloc, alloc_idx, head_idx,
        input  retire, flush
    );

    modport commit (
        output retire, flush
    );

    modport store (
        input alloc, alloc_idx, head_idx, retire, flush
    );
endinterface

//--- rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH  = 16;
    localparam int ROB_IDX_W  = 4;
    // index plus one wrap bit
    localparam int ROB_PTR_W  = 5;

    // register and datapath widths
    localparam int ARCH_REG_W = 5;
    localparam int PHYS_REG_W = 6;
    localparam int XLEN       = 32;
    localparam int ORDER_W    = 64;

    // rv32i major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv_opcode_e;

    // one buffer slot
    typedef struct packed {
        logic                  valid;
        // result has come back on a completion port
        logic                  done;
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       pc_rdata;
        // next pc, replaced by the target for a taken branch
        logic [XLEN-1:0]       pc_wdata;
        logic [ARCH_REG_W-1:0] rd_addr;
        logic [ARCH_REG_W-1:0] rs1_addr;
        logic [ARCH_REG_W-1:0] rs2_addr;
        logic [PHYS_REG_W-1:0] pd;
        logic                  regf_we;
        logic [XLEN-1:0]       rd_wdata;
        // taken branch, squash everything younger at retire
        logic                  redirect;
        logic [XLEN-1:0]       redirect_addr;
    } rob_entry_t;

endpackage
